// File: gte_config.svh
`ifndef GTE_CONFIG_SVH
`define GTE_CONFIG_SVH

// ------------------------------------------------------------
// Register port geometry
// ------------------------------------------------------------

// Full register as seen by the CPU
`define GTE_DATA_W      32

// Half register, the unit of SZ, IR and 16-bit promotion
`define GTE_HALF_W      16

// Register number, bit 5 picks data or control bank
`define GTE_REG_ID_W    6

// ------------------------------------------------------------
// Storage sizing
// ------------------------------------------------------------

// Entries per bank, data and control alike
`define GTE_FILE_DEPTH  32

// Lead count result, holds 1..32
`define GTE_LZC_W       6

`endif

// File: gteRegPkg.sv
`include "gte_config.svh"

package gteRegPkg;

	// ------------------------------------------------------------
	// CPU register numbers
	// ------------------------------------------------------------
	typedef enum logic [`GTE_REG_ID_W-1:0] {
		// Data bank, 0..31
		VXY0 = 6'd0,
		VZ0  = 6'd1,
		VZ1  = 6'd3,
		VZ2  = 6'd5,
		OTZ  = 6'd7,
		IR0  = 6'd8,  IR1  = 6'd9,  IR2  = 6'd10, IR3  = 6'd11,
		SXY0 = 6'd12, SXY1 = 6'd13, SXY2 = 6'd14, SXYP = 6'd15,
		SZ0  = 6'd16, SZ1  = 6'd17, SZ2  = 6'd18, SZ3  = 6'd19,
		IRGB = 6'd28,
		ORGB = 6'd29,
		LZCS = 6'd30,
		LZCR = 6'd31,
		// Control bank, 32..63
		R33  = 6'd36,
		L33  = 6'd44,
		LB3  = 6'd52,
		H    = 6'd58,
		DQA  = 6'd59,
		DQB  = 6'd60,
		ZSF3 = 6'd61,
		ZSF4 = 6'd62,
		FLAG = 6'd63 // Stored plainly, no status logic behind it
	} gteRegId_e;

	// One CPU port access, valid for a single cycle
	typedef struct packed {
		logic                     wrEn;
		logic                     rdEn;   // Ignored when wrEn is high
		logic [`GTE_REG_ID_W-1:0] regId;
		logic [`GTE_DATA_W-1:0]   wrData;
	} cpuReq_t;

	// Live contents of the special registers
	typedef struct packed {
		logic [2:0][`GTE_DATA_W-1:0] sxy;  // Screen FIFO, {SY, SX} per entry
		logic [3:0][`GTE_HALF_W-1:0] sz;
		logic [3:0][`GTE_HALF_W-1:0] ir;
		logic [14:0]                 orgb; // 5:5:5 packed, IR1 in the low field
	} geomView_t;

	// Registered words out of the general banks
	typedef struct packed {
		logic [`GTE_DATA_W-1:0] dataWord;
		logic [`GTE_DATA_W-1:0] ctrlWord;
		logic [`GTE_LZC_W-1:0]  leadCnt;  // Captured at the LZCS write
	} generalView_t;

	// ------------------------------------------------------------
	// Where a read word comes from
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		FILE_DATA,
		FILE_CTRL,
		GEOM_SXY,
		GEOM_SZ,
		GEOM_IR,
		GEOM_ORGB,
		LEAD_CNT
	} rdSrc_e;

endpackage

// File: gteGeomRegs.sv
`include "gte_config.svh"

module gteGeomRegs (
	input  logic                 i_clk,
	input  logic                 i_rstN,
	input  gteRegPkg::cpuReq_t   i_req,
	output gteRegPkg::geomView_t o_view
);
	import gteRegPkg::*;

	localparam int ChanW = 5; // One colour channel of IRGB/ORGB

	logic [2:0][`GTE_DATA_W-1:0] sxyQ;  // SXY0..SXY2
	logic [3:0][`GTE_HALF_W-1:0] szQ;   // SZ0..SZ3
	logic [3:0][`GTE_HALF_W-1:0] irQ;   // IR0..IR3
	logic [1:0]                  slot;  // Entry index inside a register group
	logic [`GTE_HALF_W-1:0]      wrHalf;

	// ------------------------------------------------------------
	// Colour helpers
	// ------------------------------------------------------------

	// Saturate an IR value down to a 5-bit channel
	function automatic logic [ChanW-1:0] orgbChannel(input logic [`GTE_HALF_W-1:0] ir);
		logic [ChanW-1:0] chan;
		if (ir[`GTE_HALF_W-1]) begin
			chan = '0;         // Negative clamps to black
		end else if (|ir[14:12]) begin
			chan = '1;         // Above 0x0FFF saturates
		end else begin
			chan = ir[11:7];
		end
		return chan;
	endfunction

	// IRGB field lands at bits 11:7 of the IR value
	function automatic logic [`GTE_HALF_W-1:0] irgbExpand(input logic [ChanW-1:0] field);
		return {{(`GTE_HALF_W - ChanW - 7){1'b0}}, field, 7'b0};
	endfunction

	assign slot   = i_req.regId[1:0];            // Groups are 4-aligned
	assign wrHalf = i_req.wrData[`GTE_HALF_W-1:0];

	// ------------------------------------------------------------
	// CPU writes
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			sxyQ <= '0;
			szQ  <= '0;
			irQ  <= '0;
		end else if (i_req.wrEn) begin
			case (i_req.regId)
				SXY0, SXY1, SXY2: sxyQ[slot] <= i_req.wrData; // Direct load, no shift
				SXYP: begin
					// Push, oldest entry drops out of SXY0
					sxyQ[0] <= sxyQ[1];
					sxyQ[1] <= sxyQ[2];
					sxyQ[2] <= i_req.wrData;
				end
				SZ0, SZ1, SZ2, SZ3: szQ[slot] <= wrHalf;
				IR0, IR1, IR2, IR3: irQ[slot] <= wrHalf;
				IRGB: begin
					// IR0 is left alone
					irQ[1] <= irgbExpand(i_req.wrData[4:0]);   // Red
					irQ[2] <= irgbExpand(i_req.wrData[9:5]);   // Green
					irQ[3] <= irgbExpand(i_req.wrData[14:10]); // Blue
				end
				default: ;                                     // Not a special register
			endcase
		end
	end

	// ------------------------------------------------------------
	// View out, ORGB always tracks IR1..IR3
	// ------------------------------------------------------------
	assign o_view.sxy  = sxyQ;
	assign o_view.sz   = szQ;
	assign o_view.ir   = irQ;
	assign o_view.orgb = {orgbChannel(irQ[3]), orgbChannel(irQ[2]), orgbChannel(irQ[1])};

endmodule

// File: gteGeneralRegs.sv
`include "gte_config.svh"

module gteGeneralRegs (
	input  logic                    i_clk,
	input  gteRegPkg::cpuReq_t      i_req,
	output gteRegPkg::generalView_t o_view
);
	import gteRegPkg::*;

	localparam int AddrW = $clog2(`GTE_FILE_DEPTH);

	// Bank 0 is data, bank 1 is control
	logic [`GTE_DATA_W-1:0] regFile [2][`GTE_FILE_DEPTH];
	logic [`GTE_DATA_W-1:0] wordQ   [2];                   // Last word read per bank
	logic [`GTE_LZC_W-1:0]  leadCntQ;
	logic [AddrW-1:0]       addr;
	logic                   bank;
	logic                   rdStrobe;

	// ------------------------------------------------------------
	// Leading sign-bit count
	// ------------------------------------------------------------

	// Bit 31 itself counts, so the result is never zero
	function automatic logic [`GTE_LZC_W-1:0] leadCount(input logic [`GTE_DATA_W-1:0] value);
		logic [`GTE_LZC_W-1:0] cnt;
		logic                  run;
		cnt = `GTE_LZC_W'(1);
		run = 1'b1;
		for (int i = `GTE_DATA_W - 2; i >= 0; i--) begin
			if (run && (value[i] == value[`GTE_DATA_W-1])) begin
				cnt = cnt + 1'b1;
			end else begin
				run = 1'b0;   // First differing bit ends the run
			end
		end
		return cnt;
	endfunction

	assign addr     = i_req.regId[AddrW-1:0];
	assign bank     = i_req.regId[`GTE_REG_ID_W-1];
	assign rdStrobe = i_req.rdEn & ~i_req.wrEn;      // Write has priority

	// ------------------------------------------------------------
	// Register banks, one write and one read port
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_req.wrEn) begin
			regFile[bank][addr] <= i_req.wrData;     // Every number is stored, specials too
		end
		if (rdStrobe) begin
			wordQ[bank] <= regFile[bank][addr];      // Other bank holds its last word
		end
	end

	// Count is latched with the write, LZCR is then a plain lookup
	always_ff @(posedge i_clk) begin
		if (i_req.wrEn && (i_req.regId == LZCS)) begin
			leadCntQ <= leadCount(i_req.wrData);
		end
	end

	assign o_view.dataWord = wordQ[0];
	assign o_view.ctrlWord = wordQ[1];
	assign o_view.leadCnt  = leadCntQ;

endmodule

// File: gteReadMux.sv
`include "gte_config.svh"

module gteReadMux (
	input  logic                    i_clk,
	input  logic                    i_rstN,
	input  gteRegPkg::cpuReq_t      i_req,
	input  gteRegPkg::geomView_t    i_geom,
	input  gteRegPkg::generalView_t i_general,
	output logic [`GTE_DATA_W-1:0]  o_rdData,
	output logic                    o_rdValid
);
	import gteRegPkg::*;

	logic                     rdStrobe;
	rdSrc_e                   src;
	rdSrc_e                   srcQ;
	logic                     signExt;
	logic                     zeroExt;
	logic                     signExtQ;
	logic                     zeroExtQ;
	logic [`GTE_REG_ID_W-1:0] regIdQ;
	logic [`GTE_DATA_W-1:0]   rawWord;
	logic [`GTE_HALF_W-1:0]   upperHalf;

	assign rdStrobe = i_req.rdEn & ~i_req.wrEn; // No read when a write is present

	// ------------------------------------------------------------
	// Decode on the request cycle
	// ------------------------------------------------------------
	always_comb begin
		src = FILE_DATA;
		if (i_req.regId[`GTE_REG_ID_W-1]) begin
			src = FILE_CTRL;
		end
		case (i_req.regId)
			SXY0, SXY1, SXY2, SXYP: src = GEOM_SXY;
			SZ0, SZ1, SZ2, SZ3:     src = GEOM_SZ;
			IR0, IR1, IR2, IR3:     src = GEOM_IR;
			IRGB, ORGB:             src = GEOM_ORGB; // IRGB mirrors ORGB on read
			LZCR:                   src = LEAD_CNT;
			default: ;                               // Plain bank word
		endcase
	end

	// 16-bit registers promoted on the way out
	always_comb begin
		signExt = 1'b0;
		zeroExt = 1'b0;
		case (i_req.regId)
			VZ0, VZ1, VZ2, IR0, IR1, IR2, IR3, R33, L33, LB3: signExt = 1'b1;
			OTZ, SZ0, SZ1, SZ2, SZ3, H, DQA, DQB, ZSF3, ZSF4: zeroExt = 1'b1;
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// Pipeline stage
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (rdStrobe) begin
			srcQ     <= src;
			regIdQ   <= i_req.regId;
			signExtQ <= signExt;
			zeroExtQ <= zeroExt;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			o_rdValid <= 1'b0;
		end else begin
			o_rdValid <= rdStrobe;  // One pulse per accepted read
		end
	end

	// Word select in the cycle after the strobe
	always_comb begin
		case (srcQ)
			FILE_CTRL: rawWord = i_general.ctrlWord;
			GEOM_SXY:  rawWord = (regIdQ[1:0] == 2'd3) ? i_geom.sxy[2]   // SXYP reads SXY2, no shift
			                                           : i_geom.sxy[regIdQ[1:0]];
			GEOM_SZ:   rawWord = {{`GTE_HALF_W{1'b0}}, i_geom.sz[regIdQ[1:0]]};
			GEOM_IR:   rawWord = {{`GTE_HALF_W{1'b0}}, i_geom.ir[regIdQ[1:0]]};
			GEOM_ORGB: rawWord = {{(`GTE_DATA_W - $bits(i_geom.orgb)){1'b0}}, i_geom.orgb};
			LEAD_CNT:  rawWord = {{(`GTE_DATA_W - `GTE_LZC_W){1'b0}}, i_general.leadCnt};
			default:   rawWord = i_general.dataWord;
		endcase

		// Promotion only touches the upper half
		upperHalf = rawWord[`GTE_DATA_W-1:`GTE_HALF_W];
		if (signExtQ) begin
			upperHalf = {`GTE_HALF_W{rawWord[`GTE_HALF_W-1]}};
		end else if (zeroExtQ) begin
			upperHalf = '0;
		end
	end

	assign o_rdData = {upperHalf, rawWord[`GTE_HALF_W-1:0]};

endmodule

// File: gteRegBank.sv
`include "gte_config.svh"

module gteRegBank (
	input  logic                     i_clk,
	input  logic                     i_rstN,
	input  logic [`GTE_REG_ID_W-1:0] i_regId,
	input  logic                     i_wrEn,
	input  logic                     i_rdEn,
	input  logic [`GTE_DATA_W-1:0]   i_wrData,
	output logic [`GTE_DATA_W-1:0]   o_rdData,
	output logic                     o_rdValid
);
	import gteRegPkg::*;

	cpuReq_t      req;          // Same request fans out to all three parts
	geomView_t    geomView;
	generalView_t generalView;

	assign req = '{wrEn: i_wrEn, rdEn: i_rdEn, regId: i_regId, wrData: i_wrData};

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------
	gteGeomRegs uGeomRegs (
		.i_clk  (i_clk),
		.i_rstN (i_rstN),
		.i_req  (req),
		.o_view (geomView)   // SXY, SZ, IR, ORGB
	);

	gteGeneralRegs uGeneralRegs (
		.i_clk  (i_clk),
		.i_req  (req),
		.o_view (generalView) // Bank words and lead count
	);

	// ------------------------------------------------------------
	// Read return
	// ------------------------------------------------------------
	gteReadMux uReadMux (
		.i_clk     (i_clk),
		.i_rstN    (i_rstN),
		.i_req     (req),
		.i_geom    (geomView),
		.i_general (generalView),
		.o_rdData  (o_rdData),
		.o_rdValid (o_rdValid)
	);

endmodule

// File: gteRegBank_tb.sv
`include "gte_config.svh"

module gteRegBank_tb;

	logic                     i_clk;
	logic                     i_rstN;
	logic [`GTE_REG_ID_W-1:0] i_regId;
	logic                     i_wrEn;
	logic                     i_rdEn;
	logic [`GTE_DATA_W-1:0]   i_wrData;
	logic [`GTE_DATA_W-1:0]   o_rdData;
	logic                     o_rdValid;

	string                    stimLines [$]; // Non-comment lines of the stimulus file
	bit                       loaded;        // Starts the watchdog
	int                       errCount;
	int                       checkCount;
	int                       testCount;
	int                       testErrStart;  // errCount when the current test began
	string                    testName;
	logic                     pendRead;      // Read issued on the previous cycle
	logic [`GTE_DATA_W-1:0]   pendExp;
	logic [`GTE_REG_ID_W-1:0] pendId;

	gteRegBank UUT (
		.i_clk     (i_clk),
		.i_rstN    (i_rstN),
		.i_regId   (i_regId),
		.i_wrEn    (i_wrEn),
		.i_rdEn    (i_rdEn),
		.i_wrData  (i_wrData),
		.o_rdData  (o_rdData),
		.o_rdValid (o_rdValid)
	);

	always #50 i_clk = ~i_clk; // 100-unit period

	// ------------------------------------------------------------
	// Checking and reporting
	// ------------------------------------------------------------
	task automatic compareValue(input logic [`GTE_DATA_W-1:0] actual,
			input logic [`GTE_DATA_W-1:0] expected, input string what);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Runs 1 unit after an edge when the previous read is out
	task automatic checkLastCycle();
		compareValue(`GTE_DATA_W'(o_rdValid), `GTE_DATA_W'(pendRead), "rdValid");
		if (pendRead) begin
			compareValue(o_rdData, pendExp, $sformatf("read of register %0d", pendId));
		end
		pendRead = 1'b0;
	endtask

	task automatic finishTest();
		if (testName != "") begin
			testCount++;
			$display("Test %s finished: %0d errors", testName, errCount - testErrStart);
		end
		testErrStart = errCount;
	endtask

	// Pending read request must not raise o_rdValid while in reset
	task automatic applyReset();
		i_rstN = 1'b0;
		i_rdEn = 1'b1;
		repeat (2) begin
			@(posedge i_clk);
			#1;
			compareValue(`GTE_DATA_W'(o_rdValid), '0, "rdValid in reset");
		end
		i_rstN = 1'b1;
		i_rdEn = 1'b0;
	endtask

	// Returns 0 when the file cannot be opened
	function automatic int loadStimulus();
		int    fd;
		string line;
		fd = $fopen("gte_stim.txt", "r");
		if (fd == 0) begin
			return 0;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				stimLines.push_back(line); // Skip comments and blank lines
			end
		end
		$fclose(fd);
		return 1;
	endfunction

	// ------------------------------------------------------------
	// One stimulus line per cycle driven 1 unit after the edge
	// ------------------------------------------------------------
	task automatic runLine(input string line);
		string                  op;
		logic [`GTE_DATA_W-1:0] id;
		logic [`GTE_DATA_W-1:0] data;
		logic [`GTE_DATA_W-1:0] expected;
		int                     n;
		n = $sscanf(line, "%s %h %h %h", op, id, data, expected);
		if (n < 1) begin
			return;
		end
		@(posedge i_clk);
		#1;
		checkLastCycle();
		i_wrEn = 1'b0;
		i_rdEn = 1'b0;
		if (op == "T") begin
			finishTest();                           // Idle cycle between tests
			n = $sscanf(line, "%s %s", op, testName);
		end else if (op == "W") begin
			i_regId  = id[`GTE_REG_ID_W-1:0];
			i_wrData = data;
			i_wrEn   = 1'b1;
		end else if (op == "R") begin
			i_regId  = id[`GTE_REG_ID_W-1:0];
			i_rdEn   = 1'b1;
			pendRead = 1'b1;
			pendExp  = expected;
			pendId   = id[`GTE_REG_ID_W-1:0];
		end else if (op == "Z") begin
			applyReset();
		end else begin
			errCount++;
			$display("Unknown stimulus operation in line: %s", line);
		end
	endtask

	// Watchdog allows 3 cycles per stimulus line plus margin
	initial begin
		wait (loaded);
		#(stimLines.size() * 300 + 2000);
		$display("Timeout: the stimulus did not finish in time");
		$display("Errors found");
		$finish;
	end

	initial begin
		i_clk        = 1'b0;
		i_rstN       = 1'b0;
		i_regId      = '0;
		i_wrEn       = 1'b0;
		i_rdEn       = 1'b0;
		i_wrData     = '0;
		pendRead     = 1'b0;
		pendExp      = '0;
		pendId       = '0;
		errCount     = 0;
		checkCount   = 0;
		testCount    = 0;
		testErrStart = 0;
		testName     = "";
		if (loadStimulus() == 0) begin
			$display("Cannot open the stimulus file gte_stim.txt");
			$display("Errors found");
			$finish;
		end else begin
			loaded = 1'b1;
			applyReset();
			foreach (stimLines[i]) begin
				runLine(stimLines[i]);
			end
			@(posedge i_clk);                   // Drain the last read
			#1;
			checkLastCycle();
			finishTest();
			$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
			if (errCount == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

endmodule

// File: gte_stim.txt
# Columns: op regId data expected, all hex, unused columns are 0
# W write, R read and compare, Z reset for 2 cycles, T name starts a test
T resetState
R 08 0 00000000
T general
W 00 11112222 0
W 20 33334444 0
R 00 0 11112222
R 20 0 33334444
T promotion
W 01 00008001 0
W 24 12349ABC 0
W 11 ABCD8765 0
W 3A FFFF8000 0
R 01 0 FFFF8001
R 24 0 FFFF9ABC
R 11 0 00008765
R 3A 0 00008000
T screenFifo
W 0C 00010001 0
W 0D 00020002 0
W 0E 00030003 0
W 0F 00040004 0
W 0F 00050005 0
W 0F 00060006 0
R 0C 0 00040004
R 0D 0 00050005
R 0E 0 00060006
R 0F 0 00060006
T colour
W 1C 000068B1 0
R 09 0 00000880
R 0A 0 00000280
R 0B 0 00000D00
R 1D 0 000068B1
R 1C 0 000068B1
W 09 0000F000 0
W 0A 00001000 0
W 0B 00000A80 0
R 09 0 FFFFF000
R 1D 0 000057E0
T leadCount
W 1E 00000000 0
R 1F 0 00000020
W 1E FFFFFFFF 0
R 1F 0 00000020
W 1E 00F00000 0
R 1F 0 00000008
W 1E 80000000 0
R 1F 0 00000001
T resetClear
W 08 00001234 0
R 08 0 00001234
Z 0 0 0
R 08 0 00000000

// File: build.f
+incdir+.
gteRegPkg.sv
gteGeomRegs.sv
gteGeneralRegs.sv
gteReadMux.sv
gteRegBank.sv
gteRegBank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run, the exit status follows the pass message in the output
verilator --binary -f build.f --top-module gteRegBank_tb -o simv && \
./obj_dir/simv | tee /dev/stderr | grep -q "No errors" && exit 0 || exit 1
